/* all.f */
common/soc_pkg.sv
common/periph_if.sv
mio_bus/mio_bus_ctrl.sv
hdl/data_ram.sv
hdl/gpio_port.sv
counter/counter_timer.sv
hdl/disp_mux.sv
hdl/seg7_scan.sv
hdl/soc_mio_top.sv
tests/soc_mio_assertions.sv
tests/tb_soc_mio.sv

/* common/periph_if.sv */
`timescale 1ns/1ps
interface periph_if;

	logic gpio_we;
	logic counter_we;
	logic disp_we;
	soc_pkg::data_t wdata;

	modport ctrl (
		output gpio_we,
		output counter_we,
		output disp_we,
		output wdata
	);

	modport gpio (input gpio_we, input wdata);

	modport counter (input counter_we, input wdata);

	modport disp (input disp_we, input wdata); // Display register sits in disp_mux.

endinterface

/* common/soc_pkg.sv */
package soc_pkg;

	typedef logic [31:0] data_t;

	localparam int RAM_ADDR_W = 10; // Word index width of the data RAM.
	localparam int NUM_CH = 3;

	// Region codes live in address bits 31 to 28.
	localparam logic [3:0] REGION_RAM = 4'h0;
	localparam logic [3:0] REGION_DISP = 4'hE;
	localparam logic [3:0] REGION_IO = 4'hF;

	// Status word field positions.
	localparam int STAT_ZERO_LSB = 29;
	localparam int STAT_BTN_LSB = 16;
	localparam int STAT_SW_LSB = 0;

	typedef struct packed {
		logic [3:0] region;
		logic [15:0] unused;
		logic [RAM_ADDR_W-1:0] word_idx;
		logic [1:0] byte_off;
	} ram_addr_t;

	typedef struct packed {
		logic [3:0] region;
		logic [24:0] unused;
		logic reg_sel; // Address bit 2.
		logic [1:0] byte_off;
	} io_addr_t;

	typedef union packed {
		ram_addr_t ram;
		io_addr_t io;
	} bus_addr_u;

	typedef struct packed {
		logic [21:0] rsvd;
		logic [7:0] led;
		logic [1:0] ch_sel; // Counter channel select.
	} gpio_reg_t;

endpackage

/* counter/counter_timer.sv */
`timescale 1ns/1ps
module counter_timer #(
	parameter int CH0_SHIFT = 6,
	parameter int CH1_SHIFT = 9,
	parameter int CH2_SHIFT = 11
) (
	input  logic clk,
	input  logic rst,
	periph_if.counter bus,
	input  logic [1:0] counter_set,
	output logic [2:0] zero_flags,
	output soc_pkg::data_t count_sel
);

	// Tick masks, one per channel.
	localparam soc_pkg::data_t CH_MASK [soc_pkg::NUM_CH] = '{
		(32'd1 << CH0_SHIFT) - 32'd1,
		(32'd1 << CH1_SHIFT) - 32'd1,
		(32'd1 << CH2_SHIFT) - 32'd1
	};

	soc_pkg::data_t presc;
	logic [soc_pkg::NUM_CH-1:0] tick;
	soc_pkg::data_t cnt [soc_pkg::NUM_CH];

	always_ff @(posedge clk) begin
		if (rst)
			presc <= '0;
		else
			presc <= presc + 32'd1;
	end

	// A channel ticks when its low prescaler bits are all ones.
	always_comb begin
		for (int k = 0; k < soc_pkg::NUM_CH; k++)
			tick[k] = &(presc | ~CH_MASK[k]);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int k = 0; k < soc_pkg::NUM_CH; k++)
				cnt[k] <= '0;
		end else begin
			for (int k = 0; k < soc_pkg::NUM_CH; k++) begin
				if (bus.counter_we && counter_set == k)
					cnt[k] <= bus.wdata; // Reload wins over the tick.
				else if (tick[k] && cnt[k] != '0)
					cnt[k] <= cnt[k] - 32'd1;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < soc_pkg::NUM_CH; k++)
			zero_flags[k] = (cnt[k] == '0);
	end

	always_comb begin
		count_sel = '0; // Select 3 reads zero.
		for (int k = 0; k < soc_pkg::NUM_CH; k++) begin
			if (counter_set == k)
				count_sel = cnt[k];
		end
	end

endmodule

/* hdl/data_ram.sv */
`timescale 1ns/1ps
module data_ram (
	input  logic clk,
	input  logic [soc_pkg::RAM_ADDR_W-1:0] addr,
	input  logic we,
	input  soc_pkg::data_t wdata,
	output soc_pkg::data_t rdata
);

	localparam int DEPTH = 2 ** soc_pkg::RAM_ADDR_W;

	soc_pkg::data_t mem [DEPTH];

	// Single port, read before write.
	always_ff @(posedge clk) begin
		if (we)
			mem[addr] <= wdata;
		rdata <= mem[addr];
	end

endmodule

/* hdl/disp_mux.sv */
`timescale 1ns/1ps
module disp_mux (
	input  logic clk,
	input  logic rst,
	periph_if.disp bus,
	input  logic [2:0] ch_sel,
	input  soc_pkg::gpio_reg_t gpio_word,
	input  soc_pkg::data_t count_sel,
	input  logic [15:0] sw,
	input  soc_pkg::data_t last_addr,
	output soc_pkg::data_t disp_reg,
	output soc_pkg::data_t disp_data
);

	soc_pkg::data_t sel_word;

	always_ff @(posedge clk) begin
		if (rst)
			disp_reg <= '0;
		else if (bus.disp_we)
			disp_reg <= bus.wdata;
	end

	always_comb begin
		case (ch_sel)
			3'd0: sel_word = disp_reg;
			3'd1: sel_word = gpio_word;
			3'd2: sel_word = count_sel;
			3'd3: sel_word = last_addr; // Address of the last bus access.
			3'd4: sel_word = {16'h0000, sw};
			default: sel_word = '0;
		endcase
	end

	// One cycle of latency into the scan driver.
	always_ff @(posedge clk) begin
		disp_data <= sel_word;
	end

endmodule

/* hdl/gpio_port.sv */
`timescale 1ns/1ps
module gpio_port (
	input  logic clk,
	input  logic rst,
	periph_if.gpio bus,
	input  logic [15:0] sw,
	input  logic [3:0] btn,
	input  logic [2:0] zero_flags,
	output soc_pkg::gpio_reg_t gpio_word,
	output logic [7:0] led,
	output logic [1:0] counter_set,
	output soc_pkg::data_t status_word
);

	always_ff @(posedge clk) begin
		if (rst)
			gpio_word <= '0;
		else if (bus.gpio_we)
			gpio_word <= bus.wdata;
	end

	assign led = gpio_word.led;
	assign counter_set = gpio_word.ch_sel;

	// Flags of counters 2, 1, 0 sit on top, then buttons and switches.
	always_comb begin
		status_word = '0;
		status_word[soc_pkg::STAT_ZERO_LSB +: 3] = zero_flags;
		status_word[soc_pkg::STAT_BTN_LSB +: 4] = btn;
		status_word[soc_pkg::STAT_SW_LSB +: 16] = sw;
	end

endmodule

/* hdl/seg7_scan.sv */
`timescale 1ns/1ps
module seg7_scan #(
	parameter int SCAN_SHIFT = 17
) (
	input  logic clk,
	input  logic rst,
	input  soc_pkg::data_t disp_data,
	output logic [7:0] segment,
	output logic [7:0] an
);

	logic [SCAN_SHIFT+2:0] scan_cnt;
	logic [2:0] digit;
	logic [3:0] nibble;
	logic [6:0] seg_n;

	always_ff @(posedge clk) begin
		if (rst)
			scan_cnt <= '0;
		else
			scan_cnt <= scan_cnt + 1'b1;
	end

	assign digit = scan_cnt[SCAN_SHIFT+2:SCAN_SHIFT]; // Top three bits pick the digit.
	assign nibble = disp_data[digit*4 +: 4];
	assign an = ~(8'b0000_0001 << digit);

	// Segments g to a, active low.
	always_comb begin
		case (nibble)
			4'h0: seg_n = 7'h40;
			4'h1: seg_n = 7'h79;
			4'h2: seg_n = 7'h24;
			4'h3: seg_n = 7'h30;
			4'h4: seg_n = 7'h19;
			4'h5: seg_n = 7'h12;
			4'h6: seg_n = 7'h02;
			4'h7: seg_n = 7'h78;
			4'h8: seg_n = 7'h00;
			4'h9: seg_n = 7'h10;
			4'hA: seg_n = 7'h08;
			4'hB: seg_n = 7'h03;
			4'hC: seg_n = 7'h46;
			4'hD: seg_n = 7'h21;
			4'hE: seg_n = 7'h06;
			default: seg_n = 7'h0E;
		endcase
	end

	assign segment = {1'b1, seg_n}; // Decimal point stays dark.

endmodule

/* hdl/soc_mio_top.sv */
`timescale 1ns/1ps
module soc_mio_top #(
	parameter int CH0_SHIFT = 6,
	parameter int CH1_SHIFT = 9,
	parameter int CH2_SHIFT = 11,
	parameter int SCAN_SHIFT = 17
) (
	input  logic clk_100mhz,
	input  logic rst,
	input  logic [15:0] sw,
	input  logic [3:0] btn,
	input  logic req_valid,
	output logic req_ready,
	input  logic req_we,
	input  soc_pkg::data_t req_addr,
	input  soc_pkg::data_t req_wdata,
	output logic resp_valid,
	input  logic resp_ready,
	output soc_pkg::data_t resp_rdata,
	output logic [7:0] led,
	output logic [7:0] segment,
	output logic [7:0] an
);

	logic [soc_pkg::RAM_ADDR_W-1:0] ram_addr;
	logic ram_we;
	soc_pkg::data_t ram_wdata;
	soc_pkg::data_t ram_rdata;
	soc_pkg::data_t status_word;
	soc_pkg::data_t count_sel;
	soc_pkg::data_t disp_reg;
	soc_pkg::data_t disp_data;
	soc_pkg::data_t last_addr;
	soc_pkg::gpio_reg_t gpio_word;
	logic [1:0] counter_set;
	logic [2:0] zero_flags;

	periph_if pbus ();

	mio_bus_ctrl u_bus (
		.clk         (clk_100mhz),
		.rst         (rst),
		.req_valid   (req_valid),
		.req_ready   (req_ready),
		.req_we      (req_we),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.resp_valid  (resp_valid),
		.resp_ready  (resp_ready),
		.resp_rdata  (resp_rdata),
		.bus         (pbus.ctrl),
		.ram_addr    (ram_addr),
		.ram_we      (ram_we),
		.ram_wdata   (ram_wdata),
		.ram_rdata   (ram_rdata),
		.status_word (status_word),
		.count_sel   (count_sel),
		.disp_reg    (disp_reg),
		.last_addr   (last_addr)
	);

	data_ram u_ram (
		.clk   (clk_100mhz),
		.addr  (ram_addr),
		.we    (ram_we),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

	gpio_port u_gpio (
		.clk         (clk_100mhz),
		.rst         (rst),
		.bus         (pbus.gpio),
		.sw          (sw),
		.btn         (btn),
		.zero_flags  (zero_flags),
		.gpio_word   (gpio_word),
		.led         (led),
		.counter_set (counter_set),
		.status_word (status_word)
	);

	counter_timer #(
		.CH0_SHIFT (CH0_SHIFT),
		.CH1_SHIFT (CH1_SHIFT),
		.CH2_SHIFT (CH2_SHIFT)
	) u_counter (
		.clk         (clk_100mhz),
		.rst         (rst),
		.bus         (pbus.counter),
		.counter_set (counter_set),
		.zero_flags  (zero_flags),
		.count_sel   (count_sel)
	);

	disp_mux u_disp (
		.clk       (clk_100mhz),
		.rst       (rst),
		.bus       (pbus.disp),
		.ch_sel    (sw[7:5]),
		.gpio_word (gpio_word),
		.count_sel (count_sel),
		.sw        (sw),
		.last_addr (last_addr),
		.disp_reg  (disp_reg),
		.disp_data (disp_data)
	);

	seg7_scan #(
		.SCAN_SHIFT (SCAN_SHIFT)
	) u_seg (
		.clk       (clk_100mhz),
		.rst       (rst),
		.disp_data (disp_data),
		.segment   (segment),
		.an        (an)
	);

endmodule

/* mio_bus/mio_bus_ctrl.sv */
`timescale 1ns/1ps
module mio_bus_ctrl (
	input  logic clk,
	input  logic rst,
	input  logic req_valid,
	output logic req_ready,
	input  logic req_we,
	input  soc_pkg::data_t req_addr,
	input  soc_pkg::data_t req_wdata,
	output logic resp_valid,
	input  logic resp_ready,
	output soc_pkg::data_t resp_rdata,
	periph_if.ctrl bus,
	output logic [soc_pkg::RAM_ADDR_W-1:0] ram_addr,
	output logic ram_we,
	output soc_pkg::data_t ram_wdata,
	input  soc_pkg::data_t ram_rdata,
	input  soc_pkg::data_t status_word,
	input  soc_pkg::data_t count_sel,
	input  soc_pkg::data_t disp_reg,
	output soc_pkg::data_t last_addr
);

	typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} state_t;

	state_t state;
	soc_pkg::bus_addr_u addr_q;
	soc_pkg::data_t wdata_q;
	logic we_q;
	logic sel_ram;
	logic sel_disp;
	logic sel_gpio;
	logic sel_cnt;
	soc_pkg::data_t rd_mux;

	// Address decode of the registered request.
	always_comb begin
		sel_ram = addr_q.ram.region == soc_pkg::REGION_RAM;
		sel_disp = addr_q.io.region == soc_pkg::REGION_DISP;
		sel_gpio = (addr_q.io.region == soc_pkg::REGION_IO) && !addr_q.io.reg_sel;
		sel_cnt = (addr_q.io.region == soc_pkg::REGION_IO) && addr_q.io.reg_sel;
	end

	always_comb begin
		rd_mux = '0; // Unmapped regions read zero.
		if (sel_ram)
			rd_mux = ram_rdata;
		else if (sel_disp)
			rd_mux = disp_reg;
		else if (sel_gpio)
			rd_mux = status_word;
		else if (sel_cnt)
			rd_mux = count_sel;
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready) begin
			addr_q <= req_addr;
			wdata_q <= req_wdata;
			we_q <= req_we;
		end
		if (state == RESPOND && !resp_valid)
			resp_rdata <= we_q ? '0 : rd_mux; // RAM data is valid one cycle after decode.
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			resp_valid <= 1'b0;
			ram_we <= 1'b0;
			bus.gpio_we <= 1'b0;
			bus.counter_we <= 1'b0;
			bus.disp_we <= 1'b0;
		end else begin
			ram_we <= 1'b0;
			bus.gpio_we <= 1'b0;
			bus.counter_we <= 1'b0;
			bus.disp_we <= 1'b0;
			case (state)
				IDLE: begin
					if (req_valid)
						state <= ACCESS;
				end
				ACCESS: begin
					// Strobes go out for exactly one cycle.
					ram_we <= we_q && sel_ram;
					bus.gpio_we <= we_q && sel_gpio;
					bus.counter_we <= we_q && sel_cnt;
					bus.disp_we <= we_q && sel_disp;
					state <= RESPOND;
				end
				RESPOND: begin
					if (!resp_valid) begin
						resp_valid <= 1'b1;
					end else if (resp_ready) begin
						resp_valid <= 1'b0;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign req_ready = (state == IDLE);
	assign ram_addr = addr_q.ram.word_idx;
	assign ram_wdata = wdata_q;
	assign bus.wdata = wdata_q;
	assign last_addr = addr_q;

endmodule

/* tests/soc_mio_assertions.sv */
`timescale 1ns/1ps
module soc_mio_assertions (
	input logic clk,
	input logic rst,
	input logic req_valid,
	input logic req_ready,
	input logic resp_valid,
	input logic resp_ready,
	input soc_pkg::data_t resp_rdata,
	input logic ram_we,
	input logic gpio_we,
	input logic counter_we,
	input logic disp_we
);

	int fail_cnt = 0; // Failed assertions so far.

	property resp_hold;
		@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |=> resp_valid && $stable(resp_rdata);
	endproperty

	a_resp_hold: assert property (resp_hold)
		else begin
			fail_cnt++;
			$error("Response changed while resp_ready was low");
		end

	// No new request while one is in flight.
	a_busy_accept: assert property (@(posedge clk) disable iff (rst)
		req_valid && req_ready |=> !req_ready)
		else begin
			fail_cnt++;
			$error("req_ready high right after an accepted request");
		end

	a_busy_resp: assert property (@(posedge clk) disable iff (rst)
		resp_valid |-> !req_ready)
		else begin
			fail_cnt++;
			$error("req_ready high while a response is pending");
		end

	a_one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ram_we, gpio_we, counter_we, disp_we}))
		else begin
			fail_cnt++;
			$error("More than one write strobe high");
		end

endmodule

bind mio_bus_ctrl soc_mio_assertions u_assert (
	.clk        (clk),
	.rst        (rst),
	.req_valid  (req_valid),
	.req_ready  (req_ready),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready),
	.resp_rdata (resp_rdata),
	.ram_we     (ram_we),
	.gpio_we    (bus.gpio_we),
	.counter_we (bus.counter_we),
	.disp_we    (bus.disp_we)
);

/* tests/tb_soc_mio.sv */
`timescale 1ns/1ps
module tb_soc_mio;

	localparam int CLK_PERIOD = 20;
	localparam int TEST_CYCLES = 5000; // Rough length of all tests together.
	localparam int WATCHDOG_NS = 4 * TEST_CYCLES * CLK_PERIOD;
	localparam int POLL_LIMIT = 200;
	localparam int FLAG_POLLS = 1000;

	logic clk_100mhz = 1'b0;
	logic rst;
	logic [15:0] sw;
	logic [3:0] btn;
	logic req_valid;
	logic req_ready;
	logic req_we;
	soc_pkg::data_t req_addr;
	soc_pkg::data_t req_wdata;
	logic resp_valid;
	logic resp_ready;
	soc_pkg::data_t resp_rdata;
	logic [7:0] led;
	logic [7:0] segment;
	logic [7:0] an;

	int errors = 0;
	string test_name = "reset";
	logic [31:0] lfsr_state = 32'h13b6_ae49;

	soc_mio_top #(
		.CH0_SHIFT  (2),
		.CH1_SHIFT  (3),
		.CH2_SHIFT  (4),
		.SCAN_SHIFT (3)
	) u_dut (
		.clk_100mhz (clk_100mhz),
		.rst        (rst),
		.sw         (sw),
		.btn        (btn),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_we     (req_we),
		.req_addr   (req_addr),
		.req_wdata  (req_wdata),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_rdata (resp_rdata),
		.led        (led),
		.segment    (segment),
		.an         (an)
	);

	always #(CLK_PERIOD / 2) clk_100mhz = ~clk_100mhz;

	// Fibonacci LFSR, taps 32, 22, 2 and 1.
	function automatic logic next_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic soc_pkg::data_t rand_bits(input int n);
		soc_pkg::data_t r;
		r = '0;
		for (int i = 0; i < n; i++)
			r = {r[30:0], next_bit()};
		return r;
	endfunction

	// Hex digits, segments g to a, active low, point off.
	function automatic logic [7:0] seg_pattern(input logic [3:0] nibble);
		case (nibble)
			4'h0: return 8'hC0;
			4'h1: return 8'hF9;
			4'h2: return 8'hA4;
			4'h3: return 8'hB0;
			4'h4: return 8'h99;
			4'h5: return 8'h92;
			4'h6: return 8'h82;
			4'h7: return 8'hF8;
			4'h8: return 8'h80;
			4'h9: return 8'h90;
			4'hA: return 8'h88;
			4'hB: return 8'h83;
			4'hC: return 8'hC6;
			4'hD: return 8'hA1;
			4'hE: return 8'h86;
			default: return 8'h8E;
		endcase
	endfunction

	task automatic check_data(input string what, input soc_pkg::data_t exp,
			input soc_pkg::data_t act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_led(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_seg(input string what, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s, %s: expected %h, actual %h", test_name, what, exp, act);
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("CHECK FAILED %s, %s: expected %b, actual %b", test_name, what, exp, act);
		end
	endtask

	task automatic check_cycles(input string what, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("CHECK FAILED %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
		end
	endtask

	// Handshakes are sampled on the falling edge and complete on the next rising edge.
	task automatic bus_transfer(input logic we, input soc_pkg::data_t addr,
			input soc_pkg::data_t wdata, input int stall, output soc_pkg::data_t rdata);
		int wait_cnt;
		int latency;
		soc_pkg::data_t held;
		@(posedge clk_100mhz);
		#2;
		req_valid = 1'b1;
		req_we = we;
		req_addr = addr;
		req_wdata = wdata;
		resp_ready = (stall == 0);
		wait_cnt = 0;
		@(negedge clk_100mhz);
		while (!req_ready && wait_cnt < POLL_LIMIT) begin
			wait_cnt++;
			@(negedge clk_100mhz);
		end
		if (!req_ready) begin
			errors++;
			$display("%s: request at %h was never accepted", test_name, addr);
		end
		@(posedge clk_100mhz); // Accept edge.
		#2;
		req_valid = 1'b0;
		req_we = 1'b0;
		latency = 0;
		@(negedge clk_100mhz);
		while (!resp_valid && latency < POLL_LIMIT) begin
			latency++;
			@(negedge clk_100mhz);
		end
		check_cycles("response latency", 2, latency);
		held = resp_rdata;
		repeat (stall) begin
			@(negedge clk_100mhz);
			check_bit("req_ready under back-pressure", 1'b0, req_ready);
			check_bit("resp_valid under back-pressure", 1'b1, resp_valid);
			check_data("resp_rdata under back-pressure", held, resp_rdata);
		end
		if (stall > 0) begin
			@(posedge clk_100mhz);
			#2;
			resp_ready = 1'b1;
			@(negedge clk_100mhz);
		end
		rdata = resp_rdata;
		@(posedge clk_100mhz); // Response transfers.
		#2;
		resp_ready = 1'b0;
	endtask

	task automatic bus_write(input soc_pkg::data_t addr, input soc_pkg::data_t wdata);
		soc_pkg::data_t rd;
		bus_transfer(1'b1, addr, wdata, 0, rd);
		check_data("write response data", '0, rd);
	endtask

	task automatic bus_read(input soc_pkg::data_t addr, output soc_pkg::data_t rdata);
		bus_transfer(1'b0, addr, '0, 0, rdata);
	endtask

	task automatic wait_digit(input int k);
		logic [7:0] an_exp;
		int cnt;
		an_exp = ~(8'h01 << k);
		cnt = 0;
		@(negedge clk_100mhz);
		while (an !== an_exp && cnt < POLL_LIMIT) begin
			cnt++;
			@(negedge clk_100mhz);
		end
		if (an !== an_exp) begin
			errors++;
			$display("%s: digit %0d was never selected on an", test_name, k);
		end
	endtask

	task automatic check_digits(input soc_pkg::data_t exp);
		for (int k = 0; k < 8; k++) begin
			wait_digit(k);
			check_seg($sformatf("segments of digit %0d", k), seg_pattern(exp[4*k +: 4]), segment);
		end
	endtask

	task automatic test_handshake();
		soc_pkg::data_t val;
		soc_pkg::data_t rd;
		test_name = "handshake";
		@(negedge clk_100mhz);
		check_bit("resp_valid after reset", 1'b0, resp_valid);
		check_bit("req_ready after reset", 1'b1, req_ready);
		val = rand_bits(32);
		bus_write(32'h0000_0554, val);
		bus_transfer(1'b0, 32'h0000_0554, '0, 10, rd);
		check_data("read after back-pressure", val, rd);
	endtask

	task automatic test_ram();
		logic [9:0] idx [16];
		soc_pkg::data_t model [int];
		soc_pkg::data_t val;
		soc_pkg::data_t rd;
		test_name = "ram";
		for (int i = 0; i < 16; i++) begin
			idx[i] = 10'(rand_bits(10));
			val = rand_bits(32);
			model[idx[i]] = val;
			bus_write({20'h00000, idx[i], 2'b00}, val);
		end
		for (int i = 0; i < 16; i++) begin
			bus_read({20'h00000, idx[i], 2'b00}, rd);
			check_data($sformatf("word %0d", idx[i]), model[idx[i]], rd);
		end
	endtask

	task automatic test_gpio();
		soc_pkg::data_t val;
		soc_pkg::data_t rd;
		test_name = "gpio";
		val = rand_bits(32);
		bus_write(32'hF000_0000, val);
		check_led("led pattern", val[9:2], led);
		@(posedge clk_100mhz);
		#2;
		val = rand_bits(20);
		sw = val[15:0];
		btn = val[19:16];
		bus_read(32'hF000_0000, rd);
		check_data("status switches and buttons", {12'h000, btn, sw}, rd & 32'h000F_FFFF);
		bus_read(32'h4000_0000, rd);
		check_data("unmapped read", '0, rd);
	endtask

	task automatic test_counters();
		soc_pkg::data_t c1;
		soc_pkg::data_t c2;
		soc_pkg::data_t rd;
		int polls;
		test_name = "counters";
		for (int k = 0; k < 3; k++) begin
			bus_write(32'hF000_0000, 32'(k));
			bus_write(32'hF000_0004, 32'd40);
			bus_read(32'hF000_0004, c1);
			bus_read(32'hF000_0004, c2);
			// A count of zero this soon means the reload never landed.
			if (c1 > 40 || c1 == '0 || c2 > c1) begin
				errors++;
				$display("%s: counter %0d read %0d then %0d after a reload of 40",
					test_name, k, c1, c2);
			end
			polls = 0;
			do begin
				bus_read(32'hF000_0000, rd);
				polls++;
			end while (!rd[29+k] && polls < FLAG_POLLS);
			if (!rd[29+k]) begin
				errors++;
				$display("%s: zero flag of counter %0d never set", test_name, k);
			end
			bus_read(32'hF000_0004, rd);
			check_data($sformatf("count %0d at zero flag", k), '0, rd);
		end
	endtask

	task automatic test_display();
		soc_pkg::data_t val;
		soc_pkg::data_t rd;
		test_name = "display";
		@(posedge clk_100mhz);
		#2;
		sw = 16'h0000;
		val = rand_bits(32);
		bus_write(32'hE000_0000, val);
		bus_read(32'hE000_0000, rd);
		check_data("display register", val, rd);
		repeat (2) @(posedge clk_100mhz);
		check_digits(val);
		@(posedge clk_100mhz);
		#2;
		rd = rand_bits(16);
		sw = {rd[15:8], 3'b100, rd[4:0]}; // Channel 4 shows the switches.
		repeat (2) @(posedge clk_100mhz);
		check_digits({16'h0000, sw});
	endtask

	initial begin
		rst = 1'b1;
		sw = '0;
		btn = '0;
		req_valid = 1'b0;
		req_we = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		resp_ready = 1'b0;
		repeat (8) @(posedge clk_100mhz);
		#2;
		rst = 1'b0;
		test_handshake();
		test_ram();
		test_gpio();
		test_counters();
		test_display();
		errors += u_dut.u_bus.u_assert.fail_cnt;
		$display("Tests done with %0d errors", errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	initial begin
		#WATCHDOG_NS;
		$display("Watchdog expired after %0d ns with %0d errors", WATCHDOG_NS, errors);
		$display("Errors found");
		$finish;
	end

endmodule
